// ==== fetch_pkg.sv ====
package fetch_pkg;

  // address and data width of the fetch path
  localparam int XLEN = 32;

  typedef logic [XLEN-1:0] pc_t;
  typedef logic [31:0]     inst_t;

  // instructions per cache line
  localparam int LINE_WORDS = 4;
  localparam int LINE_OFF_W = $clog2(LINE_WORDS);  // word offset bits inside a line

  // addi x0, x0, 0
  localparam inst_t NOP_INST = 32'h0000_0013;

  // payload between the fetch stages
  typedef struct packed {
    pc_t   pc;
    inst_t inst;
  } fetch_item_t;

endpackage

// ==== fetch_if.sv ====
`timescale 1ns/1ps

// valid/ready link between two fetch stages
// item must hold from valid until transfer or flush
interface fetch_if;

  logic                   valid;  // producer has an item
  logic                   ready;  // consumer can take it
  fetch_pkg::fetch_item_t item;

  modport producer (
    output valid,
    output item,
    input  ready
  );

  modport consumer (
    input  valid,
    input  item,
    output ready
  );

endinterface

// ==== pc_gen.sv ====
`timescale 1ns/1ps

module pc_gen #(
  parameter fetch_pkg::pc_t RESET_PC = 32'h8000_0000
) (
  input  logic           clk,
  input  logic           rst_n,
  input  logic           redirect_i,
  input  fetch_pkg::pc_t redirect_pc_i,
  fetch_if.producer      out
);

  fetch_pkg::pc_t pc_q;
  logic           run_q;  // set once reset is gone
  logic           fire;

  // no request toward the cache while the pipe restarts
  assign out.valid = run_q && !redirect_i;
  assign out.item  = '{pc: pc_q, inst: '0};  // inst field unused on this link
  assign fire      = out.valid && out.ready;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc_q  <= RESET_PC;
      run_q <= 1'b0;
    end else begin
      run_q <= 1'b1;
      if (redirect_i) begin
        pc_q <= redirect_pc_i;  // redirect wins over advance
      end else if (fire) begin
        pc_q <= pc_q + 32'd4;
      end
    end
  end

  // instruction addresses offered to the cache are word aligned
  a_pc_aligned: assert property (
    @(posedge clk) disable iff (!rst_n)
    out.valid |-> out.item.pc[1:0] == 2'b00
  ) else $error("pc_gen: misaligned pc %h", out.item.pc);

endmodule

// ==== icache.sv ====
`timescale 1ns/1ps

module icache #(
  parameter int NUM_SETS = 16
) (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             flush_i,
  fetch_if.consumer        in,
  fetch_if.producer        out,
  output logic             mem_req_o,
  output fetch_pkg::pc_t   mem_addr_o,
  input  logic             mem_ack_i,
  input  fetch_pkg::inst_t mem_rdata_i
);

  localparam int OFF_W = fetch_pkg::LINE_OFF_W;
  localparam int IDX_W = $clog2(NUM_SETS);
  localparam int TAG_W = fetch_pkg::XLEN - 2 - OFF_W - IDX_W;

  typedef enum logic [2:0] {
    S_IDLE,
    S_LOOKUP,
    S_REFILL_REQ,
    S_REFILL_ACK_LOW,
    S_RESPOND
  } state_e;

  state_e           state_q;
  state_e           state_d;
  fetch_pkg::pc_t   req_pc_q;   // pc under lookup or refill
  logic [OFF_W-1:0] cnt_q;      // refill word counter
  logic             drop_q;     // refill result is stale after a flush
  logic [NUM_SETS-1:0] valid_q;

  logic [TAG_W-1:0] tag_mem  [NUM_SETS];
  fetch_pkg::inst_t data_mem [NUM_SETS*fetch_pkg::LINE_WORDS];

  logic [IDX_W-1:0] req_idx;
  logic [OFF_W-1:0] req_off;
  logic [TAG_W-1:0] req_tag;
  logic             hit;
  logic             accept;
  logic             out_fire;
  logic             last_word;
  logic             word_in;    // memory word captured this cycle
  logic             word_done;  // handshake fully closed
  logic             line_done;

  assign req_off = req_pc_q[2 +: OFF_W];
  assign req_idx = req_pc_q[2+OFF_W +: IDX_W];
  assign req_tag = req_pc_q[fetch_pkg::XLEN-1 -: TAG_W];
  assign hit     = valid_q[req_idx] && (tag_mem[req_idx] == req_tag);

  assign last_word = (cnt_q == OFF_W'(fetch_pkg::LINE_WORDS - 1));
  assign word_in   = (state_q == S_REFILL_REQ) && mem_ack_i;
  assign word_done = (state_q == S_REFILL_ACK_LOW) && !mem_ack_i;
  assign line_done = word_done && last_word;

  // a hit answers in the lookup cycle and a refilled line in respond
  assign out.valid = !flush_i && (((state_q == S_LOOKUP) && hit) || (state_q == S_RESPOND));
  assign out.item  = '{pc: req_pc_q, inst: data_mem[{req_idx, req_off}]};
  assign out_fire  = out.valid && out.ready;

  // take a new pc when empty or when the current one leaves
  assign in.ready = (state_q == S_IDLE) || out_fire;
  assign accept   = in.valid && in.ready;

  assign mem_req_o  = (state_q == S_REFILL_REQ);
  assign mem_addr_o = {req_pc_q[fetch_pkg::XLEN-1 : 2+OFF_W], cnt_q, 2'b00};

  always_comb begin
    state_d = state_q;
    case (state_q)
      S_IDLE: begin
        if (accept) state_d = S_LOOKUP;
      end
      S_LOOKUP: begin
        if (flush_i) begin
          state_d = S_IDLE;  // pending lookup dropped
        end else if (!hit) begin
          state_d = S_REFILL_REQ;
        end else if (out_fire) begin
          state_d = accept ? S_LOOKUP : S_IDLE;
        end
      end
      S_REFILL_REQ: begin
        if (mem_ack_i) state_d = S_REFILL_ACK_LOW;
      end
      S_REFILL_ACK_LOW: begin
        if (!mem_ack_i) begin
          if (!last_word) begin
            state_d = S_REFILL_REQ;
          end else if (drop_q || flush_i) begin
            state_d = S_IDLE;  // line kept but result discarded
          end else begin
            state_d = S_RESPOND;
          end
        end
      end
      S_RESPOND: begin
        if (flush_i) begin
          state_d = S_IDLE;
        end else if (out_fire) begin
          state_d = accept ? S_LOOKUP : S_IDLE;
        end
      end
      default: state_d = S_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= S_IDLE;
      cnt_q   <= '0;
      drop_q  <= 1'b0;
      valid_q <= '0;
    end else begin
      state_q <= state_d;
      if (word_done) cnt_q <= cnt_q + 1'b1;  // wraps to 0 after the last word
      if (state_q == S_LOOKUP) begin
        drop_q <= 1'b0;
      end else if (flush_i) begin
        drop_q <= 1'b1;
      end
      if (line_done) valid_q[req_idx] <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) req_pc_q <= in.item.pc;
    if (word_in) data_mem[{req_idx, cnt_q}] <= mem_rdata_i;
    if (line_done) tag_mem[req_idx] <= req_tag;
  end

  // four-phase port rules toward memory
  a_addr_stable: assert property (
    @(posedge clk) disable iff (!rst_n)
    mem_req_o && $past(mem_req_o) |-> $stable(mem_addr_o)
  ) else $error("icache: mem_addr_o changed during request");

  a_req_after_ack_low: assert property (
    @(posedge clk) disable iff (!rst_n)
    $rose(mem_req_o) |-> !$past(mem_ack_i)
  ) else $error("icache: request raised while ack still high");

endmodule

// ==== fetch_buffer.sv ====
`timescale 1ns/1ps

module fetch_buffer (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             flush_i,
  fetch_if.consumer        in,
  output logic             inst_valid_o,
  output fetch_pkg::inst_t inst_o,
  output fetch_pkg::pc_t   pc_o,
  input  logic             inst_ready_i
);

  logic                   full_q;
  fetch_pkg::fetch_item_t item_q;
  logic                   take_in;

  // room when empty or when decode takes the held item
  assign in.ready = !full_q || inst_ready_i;
  assign take_in  = in.valid && in.ready;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      full_q <= 1'b0;
    end else if (flush_i) begin
      full_q <= 1'b0;  // squash old path
    end else if (take_in) begin
      full_q <= 1'b1;
    end else if (inst_ready_i) begin
      full_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (take_in) item_q <= in.item;
  end

  assign inst_valid_o = full_q && !flush_i;  // nothing old leaves in the redirect cycle
  assign inst_o       = inst_valid_o ? item_q.inst : fetch_pkg::NOP_INST;  // bubble
  assign pc_o         = item_q.pc;

  // decode sees a steady instruction while it stalls
  a_hold_when_stalled: assert property (
    @(posedge clk) disable iff (!rst_n)
    inst_valid_o && !inst_ready_i |=>
      flush_i || (inst_valid_o && $stable(inst_o) && $stable(pc_o))
  ) else $error("fetch_buffer: output changed while stalled");

endmodule

// ==== fetch_top.sv ====
`timescale 1ns/1ps

module fetch_top #(
  parameter fetch_pkg::pc_t RESET_PC = 32'h8000_0000,
  parameter int             NUM_SETS = 16
) (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             redirect_i,     // branch, jump, trap or mret
  input  fetch_pkg::pc_t   redirect_pc_i,
  output logic             inst_valid_o,
  output fetch_pkg::inst_t inst_o,
  output fetch_pkg::pc_t   pc_o,
  input  logic             inst_ready_i,   // decode back-pressure
  output logic             mem_req_o,
  output fetch_pkg::pc_t   mem_addr_o,
  input  logic             mem_ack_i,
  input  fetch_pkg::inst_t mem_rdata_i
);

  fetch_if pc_link ();    // pc_gen to icache
  fetch_if inst_link ();  // icache to fetch_buffer

  pc_gen #(
    .RESET_PC (RESET_PC)
  ) u_pc_gen (
    .clk           (clk),
    .rst_n         (rst_n),
    .redirect_i    (redirect_i),
    .redirect_pc_i (redirect_pc_i),
    .out           (pc_link.producer)
  );

  icache #(
    .NUM_SETS (NUM_SETS)
  ) u_icache (
    .clk         (clk),
    .rst_n       (rst_n),
    .flush_i     (redirect_i),
    .in          (pc_link.consumer),
    .out         (inst_link.producer),
    .mem_req_o   (mem_req_o),
    .mem_addr_o  (mem_addr_o),
    .mem_ack_i   (mem_ack_i),
    .mem_rdata_i (mem_rdata_i)
  );

  fetch_buffer u_fetch_buffer (
    .clk          (clk),
    .rst_n        (rst_n),
    .flush_i      (redirect_i),
    .in           (inst_link.consumer),
    .inst_valid_o (inst_valid_o),
    .inst_o       (inst_o),
    .pc_o         (pc_o),
    .inst_ready_i (inst_ready_i)
  );

endmodule

// ==== tb_fetch_check.sv ====
`timescale 1ns/1ps

module tb_fetch_check #(
  parameter logic [31:0] RESET_PC = 32'h8000_0000
) (
  input  logic         clk,
  input  logic         rst_n,
  input  logic         redirect_i,
  input  logic [31:0]  redirect_pc_i,
  input  logic         inst_valid_i,
  input  logic [31:0]  inst_i,
  input  logic [31:0]  pc_i,
  input  logic         inst_ready_i,
  input  logic         mem_req_i,
  input  logic [31:0]  mem_addr_i,
  input  logic         mem_ack_i,
  input  int           test_id_i,
  input  logic [127:0] test_name_i,
  input  logic [31:0]  test_base_i,
  input  logic [31:0]  test_count_i,
  input  logic [31:0]  test_hs_i,
  output int           pc_errs_o,
  output int           data_errs_o,
  output int           mem_errs_o,
  output int           hold_errs_o
);

  localparam int LINE_BYTES = fetch_pkg::LINE_WORDS * 4;

  int           cur_id;
  logic [127:0] name;
  logic [31:0]  exp_hs;
  logic [31:0]  line_lo;     // first line of the consumed range
  logic [31:0]  line_hi;
  int           hs_cnt;
  int           refill_pos;  // word position inside the current refill
  logic [31:0]  last_addr;
  logic [31:0]  exp_pc;
  logic         held;
  logic [31:0]  held_inst;
  logic [31:0]  held_pc;

  function automatic logic [31:0] mem_word(input logic [31:0] addr);
    return {addr[15:0], addr[31:16]} ^ 32'h0000_0013;
  endfunction

  function automatic logic [31:0] line_of(input logic [31:0] a);
    return a & ~32'(LINE_BYTES - 1);
  endfunction

  task automatic open_test();
    cur_id  = test_id_i;
    name    = test_name_i;
    exp_hs  = test_hs_i;
    line_lo = line_of(test_base_i);
    line_hi = line_of(test_base_i + 32'd4 * test_count_i - 32'd4);
    hs_cnt  = 0;
  endtask

  task automatic close_test();
    if (hs_cnt != int'(exp_hs)) begin
      $display("ERR %0s handshakes expected %0d actual %0d", name, exp_hs, hs_cnt);
      mem_errs_o++;
    end
  endtask

  task automatic compare_delivery();
    if (redirect_i) begin
      exp_pc = redirect_pc_i;  // old path squashed from here on
    end else if (inst_valid_i && inst_ready_i) begin
      if (pc_i !== exp_pc) begin
        $display("ERR %0s pc expected %h actual %h", name, exp_pc, pc_i);
        pc_errs_o++;
      end
      if (inst_i !== mem_word(exp_pc)) begin
        $display("ERR %0s inst expected %h actual %h", name, mem_word(exp_pc), inst_i);
        data_errs_o++;
      end
      exp_pc = exp_pc + 32'd4;
    end else if (!inst_valid_i && inst_i !== fetch_pkg::NOP_INST) begin
      $display("ERR %0s bubble expected %h actual %h", name, fetch_pkg::NOP_INST, inst_i);
      data_errs_o++;
    end
  endtask

  task automatic verify_hold();
    if (held && !redirect_i) begin
      if (!inst_valid_i || inst_i !== held_inst || pc_i !== held_pc) begin
        $display("ERR %0s stalled output expected pc %h inst %h actual pc %h inst %h valid %b",
                 name, held_pc, held_inst, pc_i, inst_i, inst_valid_i);
        hold_errs_o++;
      end
    end
    held      = inst_valid_i && !inst_ready_i;
    held_inst = inst_i;
    held_pc   = pc_i;
  endtask

  task automatic track_refill();
    logic [31:0] exp_addr;
    if (mem_req_i && mem_ack_i) begin
      exp_addr = (refill_pos == 0) ? line_of(mem_addr_i) : last_addr + 32'd4;
      if (mem_addr_i !== exp_addr) begin
        $display("ERR %0s refill address expected %h actual %h", name, exp_addr, mem_addr_i);
        mem_errs_o++;
      end
      last_addr  = mem_addr_i;
      refill_pos = (refill_pos + 1) % fetch_pkg::LINE_WORDS;
      if (line_of(mem_addr_i) >= line_lo && line_of(mem_addr_i) <= line_hi) hs_cnt++;
    end
  endtask

  // sample mid-cycle where inputs and outputs are settled
  always @(negedge clk) begin
    if (!rst_n) begin
      exp_pc      = RESET_PC;
      held        = 1'b0;
      refill_pos  = 0;
      pc_errs_o   = 0;
      data_errs_o = 0;
      mem_errs_o  = 0;
      hold_errs_o = 0;
      open_test();
    end else begin
      if (test_id_i != cur_id) begin
        close_test();
        open_test();
      end
      compare_delivery();
      verify_hold();
      track_refill();
    end
  end

endmodule

// ==== tb_fetch.sv ====
`timescale 1ns/1ps

module tb_fetch;

  localparam fetch_pkg::pc_t RESET_PC = 32'h8000_0000;
  localparam int             NUM_SETS = 16;
  localparam int             ROWS     = 9;  // row 0 runs straight out of reset

  typedef logic [8*16-1:0] name_t;

  typedef struct packed {
    name_t       name;
    logic [31:0] target;  // redirect pc
    logic [31:0] count;   // instructions to consume
    logic        stall;   // random back-pressure from decode
    logic [31:0] hs;      // handshakes expected on the lines of the consumed range
  } row_t;

  logic             clk;
  logic             rst_n;
  logic             redirect_i;
  fetch_pkg::pc_t   redirect_pc_i;
  logic             inst_valid_o;
  fetch_pkg::inst_t inst_o;
  fetch_pkg::pc_t   pc_o;
  logic             inst_ready_i;
  logic             mem_req_o;
  fetch_pkg::pc_t   mem_addr_o;
  logic             mem_ack_i;
  fetch_pkg::inst_t mem_rdata_i;

  logic [31:0] lcg_state = 32'h241f;
  int          test_id;
  row_t        cur;
  int          pc_errs;
  int          data_errs;
  int          mem_errs;
  int          hold_errs;

  function automatic row_t table_row(input int i);
    row_t r;
    case (i)
      0: r = '{name_t'("reset_start"),  RESET_PC,      32'd4,  1'b0, 32'd4};
      1: r = '{name_t'("cold_run"),     32'h8000_0100, 32'd12, 1'b0, 32'd12};
      2: r = '{name_t'("warm_rerun"),   32'h8000_0100, 32'd12, 1'b0, 32'd0};
      3: r = '{name_t'("redirect_mid"), 32'h8000_0404, 32'd3,  1'b0, 32'd4};
      4: r = '{name_t'("stall_random"), 32'h8000_0200, 32'd20, 1'b1, 32'd20};
      5: r = '{name_t'("evict_a"),      32'h8000_0600, 32'd4,  1'b0, 32'd4};
      6: r = '{name_t'("evict_b"),      32'h8000_0700, 32'd4,  1'b0, 32'd4};  // same set as evict_a
      7: r = '{name_t'("evict_return"), 32'h8000_0600, 32'd4,  1'b0, 32'd4};
      default: r = '{name_t'("stall_warm"), 32'h8000_0600, 32'd4, 1'b1, 32'd0};
    endcase
    return r;
  endfunction

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // memory image with address halves swapped and xored with an addi pattern
  function automatic logic [31:0] mem_word(input logic [31:0] addr);
    return {addr[15:0], addr[31:16]} ^ 32'h0000_0013;
  endfunction

  function automatic int watchdog_cycles();
    int   total;
    row_t r;
    total = 0;
    for (int i = 0; i < ROWS; i++) begin
      r = table_row(i);
      total += int'(r.count);
    end
    return total * 40 + 2000;
  endfunction

  fetch_top #(
    .RESET_PC (RESET_PC),
    .NUM_SETS (NUM_SETS)
  ) DUT (
    .clk           (clk),
    .rst_n         (rst_n),
    .redirect_i    (redirect_i),
    .redirect_pc_i (redirect_pc_i),
    .inst_valid_o  (inst_valid_o),
    .inst_o        (inst_o),
    .pc_o          (pc_o),
    .inst_ready_i  (inst_ready_i),
    .mem_req_o     (mem_req_o),
    .mem_addr_o    (mem_addr_o),
    .mem_ack_i     (mem_ack_i),
    .mem_rdata_i   (mem_rdata_i)
  );

  tb_fetch_check #(
    .RESET_PC (RESET_PC)
  ) u_check (
    .clk           (clk),
    .rst_n         (rst_n),
    .redirect_i    (redirect_i),
    .redirect_pc_i (redirect_pc_i),
    .inst_valid_i  (inst_valid_o),
    .inst_i        (inst_o),
    .pc_i          (pc_o),
    .inst_ready_i  (inst_ready_i),
    .mem_req_i     (mem_req_o),
    .mem_addr_i    (mem_addr_o),
    .mem_ack_i     (mem_ack_i),
    .test_id_i     (test_id),
    .test_name_i   (cur.name),
    .test_base_i   (cur.target),
    .test_count_i  (cur.count),
    .test_hs_i     (cur.hs),
    .pc_errs_o     (pc_errs),
    .data_errs_o   (data_errs),
    .mem_errs_o    (mem_errs),
    .hold_errs_o   (hold_errs)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // decode side that counts taken instructions under optional random stalls
  task automatic consume(input int count, input logic stall);
    int          got;
    logic [31:0] rnd;
    got = 0;
    while (got < count) begin
      rnd = lcg_next();
      inst_ready_i = stall ? rnd[16] : 1'b1;
      @(negedge clk);
      if (inst_valid_o && inst_ready_i) got++;
      @(posedge clk);
      #1;
    end
    inst_ready_i = 1'b0;
  endtask

  // four-phase responder with 0 to 3 cycles of latency
  initial begin : mem_responder
    int          delay;
    logic [31:0] rnd;
    mem_ack_i   = 1'b0;
    mem_rdata_i = '0;
    forever begin
      @(negedge clk);
      if (rst_n && mem_req_o && !mem_ack_i) begin
        rnd   = lcg_next();
        delay = int'(rnd[17:16]);
        repeat (delay) @(posedge clk);
        @(posedge clk);
        #1;
        mem_ack_i   = 1'b1;
        mem_rdata_i = mem_word(mem_addr_o);
        do begin
          @(negedge clk);
        end while (mem_req_o);
        @(posedge clk);
        #1;
        mem_ack_i = 1'b0;
      end
    end
  end

  initial begin : stimulus
    row_t r;
    int   errors;
    rst_n         = 1'b0;
    redirect_i    = 1'b0;
    redirect_pc_i = '0;
    inst_ready_i  = 1'b0;
    test_id       = 0;
    cur           = table_row(0);
    repeat (10) @(posedge clk);
    #1;
    rst_n = 1'b1;
    for (int i = 0; i < ROWS; i++) begin
      r = table_row(i);
      if (i > 0) begin
        cur           = r;
        test_id       = i;
        redirect_i    = 1'b1;  // one cycle pulse
        redirect_pc_i = r.target;
        @(posedge clk);
        #1;
        redirect_i = 1'b0;
      end
      consume(int'(r.count), r.stall);
    end
    test_id = ROWS;  // closes the last row in the checker
    @(negedge clk);
    @(posedge clk);
    errors = pc_errs + data_errs + mem_errs + hold_errs;
    $display("errors: pc %0d, data %0d, memory %0d, hold %0d",
             pc_errs, data_errs, mem_errs, hold_errs);
    if (errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

  initial begin : watchdog
    repeat (watchdog_cycles()) @(posedge clk);
    $display("timeout: the fetch path stopped delivering instructions before the table ended");
    $display("Test failures found");
    $finish;
  end

endmodule

// ==== build.f ====
fetch_pkg.sv
fetch_if.sv
pc_gen.sv
icache.sv
fetch_buffer.sv
fetch_top.sv
tb_fetch_check.sv
tb_fetch.sv

// ==== run.sh ====
#!/bin/sh
# build the fetch testbench with Verilator, run it, and judge the run from its log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module tb_fetch -f build.f -o tb_fetch_sim \
  && ./obj_dir/tb_fetch_sim > sim.log 2>&1 \
  || { echo "build or simulation run failed"; cat sim.log 2>/dev/null; exit 1; }
cat sim.log
grep -q 'All tests passed!' sim.log \
  && echo "PASS" \
  || { echo "FAIL"; exit 1; }
